/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_axi_rd_xbar -f sim.f
./obj_dir/Vtb_axi_rd_xbar > sim.log 2>&1 || true
cat sim.log
if grep -q "Regression failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation finished without a reported failure"

/* sim.f */
verilog/xbar_pkg.sv
verilog/ar_if.sv
verilog/r_if.sv
verilog/chan_slice.sv
verilog/ar_router.sv
verilog/r_router.sv
verilog/axi_rd_xbar.sv
verif/tb_axi_rd_xbar.sv

/* verif/tb_axi_rd_xbar.sv */
`timescale 1ns/1ps

module tb_axi_rd_xbar;

    localparam int max_tests = 32;
    localparam int hdr_lines = 2;
    // Words per test record in the data file
    localparam int rec_words = 6;
    localparam int f_master  = 0;
    localparam int f_id      = 1;
    localparam int f_addr    = 2;
    localparam int f_len     = 3;
    localparam int f_resp    = 4;
    localparam int f_data    = 5;

    logic ACLK;
    logic ARESETn;

    // Index 0 and 1 select M0/M1 or S0/S1
    logic [1:0][xbar_pkg::id_bits-1:0]    m_arid, m_rid;
    logic [1:0][xbar_pkg::addr_bits-1:0]  m_araddr;
    logic [1:0][xbar_pkg::len_bits-1:0]   m_arlen;
    logic [1:0][xbar_pkg::size_bits-1:0]  m_arsize;
    logic [1:0][xbar_pkg::burst_bits-1:0] m_arburst;
    logic [1:0]                           m_arvalid, m_arready;
    logic [1:0][xbar_pkg::data_bits-1:0]  m_rdata;
    logic [1:0][1:0]                      m_rresp;
    logic [1:0]                           m_rlast, m_rvalid, m_rready;
    logic [1:0][xbar_pkg::ids_bits-1:0]   s_arid, s_rid;
    logic [1:0][xbar_pkg::addr_bits-1:0]  s_araddr;
    logic [1:0][xbar_pkg::len_bits-1:0]   s_arlen;
    logic [1:0][xbar_pkg::size_bits-1:0]  s_arsize;
    logic [1:0][xbar_pkg::burst_bits-1:0] s_arburst;
    logic [1:0]                           s_arvalid, s_arready;
    logic [1:0][xbar_pkg::data_bits-1:0]  s_rdata;
    logic [1:0][1:0]                      s_rresp;
    logic [1:0]                           s_rlast, s_rvalid, s_rready;

    logic [31:0] raw [max_tests*rec_words];
    logic [15:0] lfsr_state;
    int          num_tests;
    int          limit;
    int          cycles;
    int          rlast_seen;

    // Master driver state with m_cur at -1 while idle
    int          m_cur [2];
    int          m_scan [2];
    int          m_beat [2];
    logic [1:0]  ar_taken;

    // Slave model state for one open burst each
    logic [1:0]                    s_busy;
    logic [xbar_pkg::ids_bits-1:0] s_id [2];
    logic [31:0]                   s_addr [2];
    int                            s_len [2];
    int                            s_beat [2];

    axi_rd_xbar axi_rd_xbar_inst (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .m0_arid(m_arid[0]), .m0_araddr(m_araddr[0]), .m0_arlen(m_arlen[0]),
        .m0_arsize(m_arsize[0]), .m0_arburst(m_arburst[0]),
        .m0_arvalid(m_arvalid[0]), .m0_arready(m_arready[0]),
        .m1_arid(m_arid[1]), .m1_araddr(m_araddr[1]), .m1_arlen(m_arlen[1]),
        .m1_arsize(m_arsize[1]), .m1_arburst(m_arburst[1]),
        .m1_arvalid(m_arvalid[1]), .m1_arready(m_arready[1]),
        .m0_rid(m_rid[0]), .m0_rdata(m_rdata[0]), .m0_rresp(m_rresp[0]),
        .m0_rlast(m_rlast[0]), .m0_rvalid(m_rvalid[0]), .m0_rready(m_rready[0]),
        .m1_rid(m_rid[1]), .m1_rdata(m_rdata[1]), .m1_rresp(m_rresp[1]),
        .m1_rlast(m_rlast[1]), .m1_rvalid(m_rvalid[1]), .m1_rready(m_rready[1]),
        .s0_arid(s_arid[0]), .s0_araddr(s_araddr[0]), .s0_arlen(s_arlen[0]),
        .s0_arsize(s_arsize[0]), .s0_arburst(s_arburst[0]),
        .s0_arvalid(s_arvalid[0]), .s0_arready(s_arready[0]),
        .s1_arid(s_arid[1]), .s1_araddr(s_araddr[1]), .s1_arlen(s_arlen[1]),
        .s1_arsize(s_arsize[1]), .s1_arburst(s_arburst[1]),
        .s1_arvalid(s_arvalid[1]), .s1_arready(s_arready[1]),
        .s0_rid(s_rid[0]), .s0_rdata(s_rdata[0]), .s0_rresp(s_rresp[0]),
        .s0_rlast(s_rlast[0]), .s0_rvalid(s_rvalid[0]), .s0_rready(s_rready[0]),
        .s1_rid(s_rid[1]), .s1_rdata(s_rdata[1]), .s1_rresp(s_rresp[1]),
        .s1_rlast(s_rlast[1]), .s1_rvalid(s_rvalid[1]), .s1_rready(s_rready[1])
    );

    initial begin
        ACLK = 1'b0;
        forever #4 ACLK = ~ACLK;
    end

    // --------------------
    // Helpers
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bit(output logic b);
        lfsr_state = lfsr_step(lfsr_state);
        b = lfsr_state[0];
    endtask

    // Named after the line in the data file
    function automatic string test_name(input int t);
        return $sformatf("test%0d", t + hdr_lines + 1);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("CHECK FAILED %s %s: expected 0x%h, actual 0x%h",
                                name, what, expected, actual));
        end
    endtask

    function automatic int next_test(input int m, input int from);
        for (int t = from; t < num_tests; t++) begin
            if (raw[t*rec_words + f_master] == 32'(m)) begin
                return t;
            end
        end
        return -1;
    endfunction

    task automatic check_beat(input int m);
        int          t;
        int          base;
        logic [31:0] exp_data;
        t = m_cur[m];
        if (t < 0) begin
            abort_run($sformatf("M%0d received an R beat with no read outstanding", m));
        end else begin
            base = t * rec_words;
            // Beat k adds 4k and DECERR beats carry zero
            if (raw[base + f_resp] == 32'(xbar_pkg::resp_okay)) begin
                exp_data = raw[base + f_data] + 32'(4 * m_beat[m]);
            end else begin
                exp_data = '0;
            end
            check_value(test_name(t), "rid", raw[base + f_id], 32'(m_rid[m]));
            check_value(test_name(t), "rresp", raw[base + f_resp], 32'(m_rresp[m]));
            check_value(test_name(t), "rdata", exp_data, m_rdata[m]);
            check_value(test_name(t), "rlast",
                        32'(m_beat[m] == int'(raw[base + f_len])), 32'(m_rlast[m]));
            m_beat[m]++;
            if (m_rlast[m]) begin
                rlast_seen++;
                m_cur[m] = -1;
            end
        end
    endtask

    // Slave AR carries the request of the master named by its top ID bit
    task automatic check_request(input int s);
        int m;
        int t;
        int base;
        m = int'(s_arid[s][xbar_pkg::ids_bits-1]);
        t = m_cur[m];
        if (t < 0) begin
            abort_run($sformatf("S%0d received a read for idle master M%0d", s, m));
        end else begin
            base = t * rec_words;
            check_value(test_name(t), "arid",
                        (32'(m) << xbar_pkg::id_bits) | raw[base + f_id], 32'(s_arid[s]));
            check_value(test_name(t), "araddr", raw[base + f_addr], s_araddr[s]);
            check_value(test_name(t), "arlen", raw[base + f_len], 32'(s_arlen[s]));
            check_value(test_name(t), "arsize", 32'(m_arsize[m]), 32'(s_arsize[s]));
            check_value(test_name(t), "arburst", 32'(m_arburst[m]), 32'(s_arburst[s]));
        end
    endtask

    // --------------------
    // Handshakes seen at the rising edge
    task automatic sample_edge();
        for (int s = 0; s < 2; s++) begin
            if (s_rvalid[s] && s_rready[s]) begin
                if (s_beat[s] == s_len[s]) begin
                    s_busy[s] = 1'b0;
                end
                s_beat[s]++;
            end
            if (s_arvalid[s] && s_arready[s]) begin
                if (s_busy[s]) begin
                    abort_run($sformatf("S%0d accepted a read while a burst was open", s));
                end else begin
                    check_request(s);
                    s_busy[s] = 1'b1;
                    s_id[s]   = s_arid[s];
                    s_addr[s] = s_araddr[s];
                    s_len[s]  = int'(s_arlen[s]);
                    s_beat[s] = 0;
                end
            end
        end
        for (int m = 0; m < 2; m++) begin
            if (m_arvalid[m] && m_arready[m]) begin
                ar_taken[m] = 1'b1;
            end
            if (m_rvalid[m] && m_rready[m]) begin
                check_beat(m);
            end
        end
    endtask

    // Falling edge drive of slave models and master drivers
    task automatic drive_inputs();
        logic b0;
        logic b1;
        int   t;
        for (int s = 0; s < 2; s++) begin
            take_bit(b0);
            s_arready[s] = b0;
            s_rvalid[s]  = s_busy[s];
            s_rid[s]     = s_id[s];
            // S1 data has bit 31 set
            s_rdata[s]   = (s_addr[s] + 32'(4 * s_beat[s])) | (s == 1 ? 32'h8000_0000 : 32'h0);
            s_rresp[s]   = xbar_pkg::resp_okay;
            s_rlast[s]   = (s_beat[s] == s_len[s]);
        end
        for (int m = 0; m < 2; m++) begin
            if (ar_taken[m]) begin
                m_arvalid[m] = 1'b0;
                ar_taken[m]  = 1'b0;
            end
            if (m_cur[m] < 0) begin
                t = next_test(m, m_scan[m]);
                if (t >= 0) begin
                    m_cur[m]     = t;
                    m_scan[m]    = t + 1;
                    m_beat[m]    = 0;
                    m_arid[m]    = raw[t*rec_words + f_id][xbar_pkg::id_bits-1:0];
                    m_araddr[m]  = raw[t*rec_words + f_addr];
                    m_arlen[m]   = raw[t*rec_words + f_len][xbar_pkg::len_bits-1:0];
                    m_arsize[m]  = 3'd2;
                    m_arburst[m] = 2'b01;
                    m_arvalid[m] = 1'b1;
                end
            end
            // RREADY high three times out of four
            take_bit(b0);
            take_bit(b1);
            m_rready[m] = b0 | b1;
        end
    endtask

    task automatic run_cycle();
        @(posedge ACLK);
        sample_edge();
        @(negedge ACLK);
        drive_inputs();
    endtask

    // --------------------
    // Main sequence
    initial begin
        ARESETn    = 1'b0;
        m_arid     = '0;
        m_araddr   = '0;
        m_arlen    = '0;
        m_arsize   = '0;
        m_arburst  = '0;
        m_arvalid  = '0;
        m_rready   = '0;
        s_arready  = '0;
        s_rid      = '0;
        s_rdata    = '0;
        s_rresp    = '0;
        s_rlast    = '0;
        s_rvalid   = '0;
        ar_taken   = '0;
        s_busy     = '0;
        lfsr_state = 16'd97;
        for (int i = 0; i < 2; i++) begin
            m_cur[i]  = -1;
            m_scan[i] = 0;
            m_beat[i] = 0;
            s_id[i]   = '0;
            s_addr[i] = '0;
            s_len[i]  = 0;
            s_beat[i] = 0;
        end

        // Unused records keep an all-ones master field
        for (int i = 0; i < max_tests*rec_words; i++) begin
            raw[i] = '1;
        end
        $readmemh("verif/xbar_tests.hex", raw);
        num_tests = 0;
        while (num_tests < max_tests && raw[num_tests*rec_words + f_master] <= 32'd1) begin
            num_tests++;
        end
        if (num_tests == 0) begin
            abort_run("No tests were read from verif/xbar_tests.hex");
        end
        limit = 200;
        for (int t = 0; t < num_tests; t++) begin
            limit += (int'(raw[t*rec_words + f_len]) + 1) * 20;
        end

        repeat (16) @(posedge ACLK);
        @(negedge ACLK);
        ARESETn = 1'b1;
        @(posedge ACLK);
        for (int i = 0; i < 2; i++) begin
            check_value("reset", $sformatf("m%0d_rvalid", i), 32'h0, 32'(m_rvalid[i]));
            check_value("reset", $sformatf("s%0d_arvalid", i), 32'h0, 32'(s_arvalid[i]));
        end

        cycles     = 0;
        rlast_seen = 0;
        while (rlast_seen < num_tests) begin
            run_cycle();
            cycles++;
            if (cycles >= limit) begin
                abort_run($sformatf("Timeout after %0d cycles with %0d of %0d bursts done",
                                    cycles, rlast_seen, num_tests));
            end
        end

        // Idle a few cycles so a stray beat would show up
        repeat (10) run_cycle();

        if (s_busy == 2'b00) begin
            $display("Regression passed");
            $finish;
        end else begin
            abort_run($sformatf("Run ended with a slave burst still open, busy flags %b",
                                s_busy));
        end
    end

endmodule

/* verif/xbar_tests.hex */
// master id addr len resp data_beat0, one test per line, all fields hex
// resp 0 is OKAY, 3 is DECERR; beat k data is data_beat0 + 4k for OKAY, 0 for DECERR
0 3 00000100 0 0 00000100
1 5 00010020 3 0 80010020
0 1 00000200 2 0 00000200
1 2 00000400 3 0 00000400
0 7 00020000 1 3 00000000
1 9 00018000 0 0 80018000
0 4 0001fff0 3 0 8001fff0
1 f 10000000 2 3 00000000
0 0 0000fff0 3 0 0000fff0
1 6 0000ff00 1 0 0000ff00
0 a fffffff0 3 3 00000000
1 b 00010100 7 0 80010100
0 c 00011000 f 0 80011000
1 d 00000800 f 0 00000800
0 e 00000040 0 0 00000040
1 8 00030000 3 3 00000000

/* verilog/ar_if.sv */
`timescale 1ns/1ps

interface ar_if;

    logic [xbar_pkg::ids_bits-1:0]   id;
    logic [xbar_pkg::addr_bits-1:0]  addr;
    logic [xbar_pkg::len_bits-1:0]   len;
    logic [xbar_pkg::size_bits-1:0]  size;
    logic [xbar_pkg::burst_bits-1:0] burst;
    logic                            valid;
    logic                            ready;

    modport src (
        output id, addr, len, size, burst, valid,
        input  ready
    );

    modport dst (
        input  id, addr, len, size, burst, valid,
        output ready
    );

endinterface

/* verilog/ar_router.sv */
`timescale 1ns/1ps

module ar_router (
    input  logic                            ACLK,
    input  logic                            ARESETn,
    input  logic [xbar_pkg::id_bits-1:0]    m0_arid, m1_arid,
    input  logic [xbar_pkg::addr_bits-1:0]  m0_araddr, m1_araddr,
    input  logic [xbar_pkg::len_bits-1:0]   m0_arlen, m1_arlen,
    input  logic [xbar_pkg::size_bits-1:0]  m0_arsize, m1_arsize,
    input  logic [xbar_pkg::burst_bits-1:0] m0_arburst, m1_arburst,
    input  logic                            m0_arvalid, m1_arvalid,
    output logic                            m0_arready, m1_arready,
    output logic                            s0_ar_valid, s1_ar_valid,
    input  logic                            s0_ar_ready, s1_ar_ready,
    output xbar_pkg::ar_payload_t           s0_ar_payload, s1_ar_payload,
    ar_if.src                               def_ar,
    input  logic [xbar_pkg::num_slaves-1:0] burst_done
);

    xbar_pkg::ar_payload_t            mst_pld [xbar_pkg::num_masters];
    xbar_pkg::target_t                mst_tgt [xbar_pkg::num_masters];
    logic [xbar_pkg::num_masters-1:0] mst_valid;
    logic [xbar_pkg::num_masters-1:0] mst_ready;

    // Per target, default target in the top slot
    logic [xbar_pkg::num_masters-1:0] tgt_req [xbar_pkg::num_slaves+1];
    xbar_pkg::ar_payload_t            tgt_pld [xbar_pkg::num_slaves+1];
    logic [xbar_pkg::num_slaves:0]    tgt_valid;
    logic [xbar_pkg::num_slaves:0]    tgt_ready;
    logic [xbar_pkg::num_slaves:0]    tgt_hold;
    logic [xbar_pkg::num_slaves:0]    tgt_sel;
    logic [xbar_pkg::num_slaves:0]    prio;
    logic [xbar_pkg::num_slaves-1:0]  busy;

    function automatic xbar_pkg::target_t decode(
        input logic [xbar_pkg::addr_bits-1:0] addr
    );
        if (addr >= xbar_pkg::s0_start && addr <= xbar_pkg::s0_end) begin
            return xbar_pkg::tgt_s0;
        end
        if (addr >= xbar_pkg::s1_start && addr <= xbar_pkg::s1_end) begin
            return xbar_pkg::tgt_s1;
        end
        return xbar_pkg::tgt_default;
    endfunction

    // --------------------
    // Decode and ID widening
    always_comb begin
        mst_valid  = {m1_arvalid, m0_arvalid};
        mst_tgt[0] = decode(m0_araddr);
        mst_tgt[1] = decode(m1_araddr);
        mst_pld[0] = '{id: {1'b0, m0_arid}, addr: m0_araddr, len: m0_arlen,
                       size: m0_arsize, burst: m0_arburst};
        mst_pld[1] = '{id: {1'b1, m1_arid}, addr: m1_araddr, len: m1_arlen,
                       size: m1_arsize, burst: m1_arburst};
    end

    // --------------------
    // Round robin per target
    assign tgt_ready = {def_ar.ready, s1_ar_ready, s0_ar_ready};
    // Default target holds through its own ready
    assign tgt_hold  = {1'b0, busy};

    always_comb begin
        for (int t = 0; t <= xbar_pkg::num_slaves; t++) begin
            for (int m = 0; m < xbar_pkg::num_masters; m++) begin
                tgt_req[t][m] = mst_valid[m] && (mst_tgt[m] == xbar_pkg::target_t'(t));
            end
            tgt_sel[t]   = tgt_req[t][prio[t]] ? prio[t] : ~prio[t];
            tgt_valid[t] = (|tgt_req[t]) && !tgt_hold[t];
            tgt_pld[t]   = mst_pld[tgt_sel[t]];
        end
        for (int m = 0; m < xbar_pkg::num_masters; m++) begin
            mst_ready[m] = tgt_valid[mst_tgt[m]] && tgt_ready[mst_tgt[m]]
                           && (tgt_sel[mst_tgt[m]] == m);
        end
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            prio <= '0;
            busy <= '0;
        end else begin
            for (int t = 0; t <= xbar_pkg::num_slaves; t++) begin
                if (tgt_valid[t] && tgt_ready[t]) begin
                    prio[t] <= ~tgt_sel[t];
                end
            end
            // Busy from AR accept until the last R beat
            for (int s = 0; s < xbar_pkg::num_slaves; s++) begin
                if (tgt_valid[s] && tgt_ready[s]) begin
                    busy[s] <= 1'b1;
                end else if (burst_done[s]) begin
                    busy[s] <= 1'b0;
                end
            end
        end
    end

    assign {m1_arready, m0_arready} = mst_ready;

    assign s0_ar_valid   = tgt_valid[xbar_pkg::tgt_s0];
    assign s0_ar_payload = tgt_pld[xbar_pkg::tgt_s0];
    assign s1_ar_valid   = tgt_valid[xbar_pkg::tgt_s1];
    assign s1_ar_payload = tgt_pld[xbar_pkg::tgt_s1];

    assign def_ar.valid = tgt_valid[xbar_pkg::tgt_default];
    assign def_ar.id    = tgt_pld[xbar_pkg::tgt_default].id;
    assign def_ar.addr  = tgt_pld[xbar_pkg::tgt_default].addr;
    assign def_ar.len   = tgt_pld[xbar_pkg::tgt_default].len;
    assign def_ar.size  = tgt_pld[xbar_pkg::tgt_default].size;
    assign def_ar.burst = tgt_pld[xbar_pkg::tgt_default].burst;

endmodule

/* verilog/axi_rd_xbar.sv */
`timescale 1ns/1ps

module axi_rd_xbar (
    input  logic                            ACLK,
    input  logic                            ARESETn,
    // Master AR
    input  logic [xbar_pkg::id_bits-1:0]    m0_arid, m1_arid,
    input  logic [xbar_pkg::addr_bits-1:0]  m0_araddr, m1_araddr,
    input  logic [xbar_pkg::len_bits-1:0]   m0_arlen, m1_arlen,
    input  logic [xbar_pkg::size_bits-1:0]  m0_arsize, m1_arsize,
    input  logic [xbar_pkg::burst_bits-1:0] m0_arburst, m1_arburst,
    input  logic                            m0_arvalid, m1_arvalid,
    output logic                            m0_arready, m1_arready,
    // Master R
    output logic [xbar_pkg::id_bits-1:0]    m0_rid, m1_rid,
    output logic [xbar_pkg::data_bits-1:0]  m0_rdata, m1_rdata,
    output logic [1:0]                      m0_rresp, m1_rresp,
    output logic                            m0_rlast, m1_rlast,
    output logic                            m0_rvalid, m1_rvalid,
    input  logic                            m0_rready, m1_rready,
    // Slave AR
    output logic [xbar_pkg::ids_bits-1:0]   s0_arid, s1_arid,
    output logic [xbar_pkg::addr_bits-1:0]  s0_araddr, s1_araddr,
    output logic [xbar_pkg::len_bits-1:0]   s0_arlen, s1_arlen,
    output logic [xbar_pkg::size_bits-1:0]  s0_arsize, s1_arsize,
    output logic [xbar_pkg::burst_bits-1:0] s0_arburst, s1_arburst,
    output logic                            s0_arvalid, s1_arvalid,
    input  logic                            s0_arready, s1_arready,
    // Slave R
    input  logic [xbar_pkg::ids_bits-1:0]   s0_rid, s1_rid,
    input  logic [xbar_pkg::data_bits-1:0]  s0_rdata, s1_rdata,
    input  logic [1:0]                      s0_rresp, s1_rresp,
    input  logic                            s0_rlast, s1_rlast,
    input  logic                            s0_rvalid, s1_rvalid,
    output logic                            s0_rready, s1_rready
);

    ar_if s0_ar ();
    ar_if s1_ar ();
    ar_if def_ar ();
    r_if  s0_r ();
    r_if  s1_r ();
    r_if  m0_r ();
    r_if  m1_r ();

    logic                            s0_req_valid, s0_req_ready;
    logic                            s1_req_valid, s1_req_ready;
    xbar_pkg::ar_payload_t           s0_req, s0_ar_q;
    xbar_pkg::ar_payload_t           s1_req, s1_ar_q;
    logic                            m0_rsp_valid, m0_rsp_ready;
    logic                            m1_rsp_valid, m1_rsp_ready;
    xbar_pkg::r_payload_t            m0_rsp, m0_r_q;
    xbar_pkg::r_payload_t            m1_rsp, m1_r_q;
    logic [xbar_pkg::num_slaves-1:0] burst_done;

    ar_router ar_router_inst (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .m0_arid(m0_arid), .m0_araddr(m0_araddr), .m0_arlen(m0_arlen),
        .m0_arsize(m0_arsize), .m0_arburst(m0_arburst),
        .m0_arvalid(m0_arvalid), .m0_arready(m0_arready),
        .m1_arid(m1_arid), .m1_araddr(m1_araddr), .m1_arlen(m1_arlen),
        .m1_arsize(m1_arsize), .m1_arburst(m1_arburst),
        .m1_arvalid(m1_arvalid), .m1_arready(m1_arready),
        .s0_ar_valid(s0_req_valid), .s0_ar_ready(s0_req_ready), .s0_ar_payload(s0_req),
        .s1_ar_valid(s1_req_valid), .s1_ar_ready(s1_req_ready), .s1_ar_payload(s1_req),
        .def_ar(def_ar), .burst_done(burst_done)
    );

    // --------------------
    // Slave AR path
    chan_slice #(.payload_t(xbar_pkg::ar_payload_t)) s0_ar_slice (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .in_valid(s0_req_valid), .in_ready(s0_req_ready), .in_payload(s0_req),
        .out_valid(s0_ar.valid), .out_ready(s0_ar.ready), .out_payload(s0_ar_q)
    );

    chan_slice #(.payload_t(xbar_pkg::ar_payload_t)) s1_ar_slice (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .in_valid(s1_req_valid), .in_ready(s1_req_ready), .in_payload(s1_req),
        .out_valid(s1_ar.valid), .out_ready(s1_ar.ready), .out_payload(s1_ar_q)
    );

    assign {s0_ar.id, s0_ar.addr, s0_ar.len, s0_ar.size, s0_ar.burst} = s0_ar_q;
    assign {s1_ar.id, s1_ar.addr, s1_ar.len, s1_ar.size, s1_ar.burst} = s1_ar_q;
    assign {s0_arid, s0_araddr, s0_arlen, s0_arsize, s0_arburst, s0_arvalid} =
        {s0_ar.id, s0_ar.addr, s0_ar.len, s0_ar.size, s0_ar.burst, s0_ar.valid};
    assign {s1_arid, s1_araddr, s1_arlen, s1_arsize, s1_arburst, s1_arvalid} =
        {s1_ar.id, s1_ar.addr, s1_ar.len, s1_ar.size, s1_ar.burst, s1_ar.valid};
    assign s0_ar.ready = s0_arready;
    assign s1_ar.ready = s1_arready;

    // --------------------
    // R path
    assign {s0_r.id, s0_r.data, s0_r.resp, s0_r.last, s0_r.valid} =
        {s0_rid, s0_rdata, s0_rresp, s0_rlast, s0_rvalid};
    assign {s1_r.id, s1_r.data, s1_r.resp, s1_r.last, s1_r.valid} =
        {s1_rid, s1_rdata, s1_rresp, s1_rlast, s1_rvalid};
    assign s0_rready = s0_r.ready;
    assign s1_rready = s1_r.ready;

    r_router r_router_inst (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .s0_r(s0_r), .s1_r(s1_r), .def_ar(def_ar),
        .m0_r_valid(m0_rsp_valid), .m0_r_ready(m0_rsp_ready), .m0_r_payload(m0_rsp),
        .m1_r_valid(m1_rsp_valid), .m1_r_ready(m1_rsp_ready), .m1_r_payload(m1_rsp),
        .burst_done(burst_done)
    );

    chan_slice #(.payload_t(xbar_pkg::r_payload_t)) m0_r_slice (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .in_valid(m0_rsp_valid), .in_ready(m0_rsp_ready), .in_payload(m0_rsp),
        .out_valid(m0_r.valid), .out_ready(m0_r.ready), .out_payload(m0_r_q)
    );

    chan_slice #(.payload_t(xbar_pkg::r_payload_t)) m1_r_slice (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .in_valid(m1_rsp_valid), .in_ready(m1_rsp_ready), .in_payload(m1_rsp),
        .out_valid(m1_r.valid), .out_ready(m1_r.ready), .out_payload(m1_r_q)
    );

    assign {m0_r.id, m0_r.data, m0_r.resp, m0_r.last} = m0_r_q;
    assign {m1_r.id, m1_r.data, m1_r.resp, m1_r.last} = m1_r_q;

    // Master index bit is dropped on the way out
    assign m0_rid = m0_r.id[xbar_pkg::id_bits-1:0];
    assign m1_rid = m1_r.id[xbar_pkg::id_bits-1:0];
    assign {m0_rdata, m0_rresp, m0_rlast, m0_rvalid} =
        {m0_r.data, m0_r.resp, m0_r.last, m0_r.valid};
    assign {m1_rdata, m1_rresp, m1_rlast, m1_rvalid} =
        {m1_r.data, m1_r.resp, m1_r.last, m1_r.valid};
    assign m0_r.ready = m0_rready;
    assign m1_r.ready = m1_rready;

endmodule

/* verilog/chan_slice.sv */
`timescale 1ns/1ps

module chan_slice #(
    parameter type payload_t = logic
) (
    input  logic     ACLK,
    input  logic     ARESETn,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_payload,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_payload
);

    logic     skid_valid;
    payload_t skid_payload;
    logic     in_fire;
    logic     load_main;

    // Skid entry only fills behind a full main entry
    assign in_ready  = !skid_valid;
    assign in_fire   = in_valid && in_ready;
    assign load_main = !out_valid || out_ready;

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (load_main) begin
            // Skid drains first, otherwise the input goes straight through
            out_valid  <= skid_valid || in_fire;
            skid_valid <= 1'b0;
        end else if (in_fire) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge ACLK) begin
        if (load_main) begin
            out_payload <= skid_valid ? skid_payload : in_payload;
        end else if (in_fire) begin
            skid_payload <= in_payload;
        end
    end

endmodule

/* verilog/r_if.sv */
`timescale 1ns/1ps

interface r_if;

    logic [xbar_pkg::ids_bits-1:0]  id;
    logic [xbar_pkg::data_bits-1:0] data;
    logic [1:0]                     resp;
    logic                           last;
    logic                           valid;
    logic                           ready;

    modport src (
        output id, data, resp, last, valid,
        input  ready
    );

    modport dst (
        input  id, data, resp, last, valid,
        output ready
    );

endinterface

/* verilog/r_router.sv */
`timescale 1ns/1ps

module r_router (
    input  logic                            ACLK,
    input  logic                            ARESETn,
    r_if.dst                                s0_r,
    r_if.dst                                s1_r,
    ar_if.dst                               def_ar,
    output logic                            m0_r_valid, m1_r_valid,
    input  logic                            m0_r_ready, m1_r_ready,
    output xbar_pkg::r_payload_t            m0_r_payload, m1_r_payload,
    output logic [xbar_pkg::num_slaves-1:0] burst_done
);

    // Sources are S0, S1 and the default responder on top
    xbar_pkg::r_payload_t             src_pld [xbar_pkg::num_slaves+1];
    logic [xbar_pkg::num_slaves:0]    src_valid;
    logic [xbar_pkg::num_slaves:0]    src_ready;
    logic [xbar_pkg::num_slaves:0]    src_fire;
    logic [xbar_pkg::num_slaves:0]    src_dst;
    logic [1:0]                       sel [xbar_pkg::num_masters];
    logic [1:0]                       lst [xbar_pkg::num_masters];
    logic [xbar_pkg::num_masters-1:0] mst_valid;
    logic [xbar_pkg::num_masters-1:0] mst_ready;

    logic                             def_busy;
    logic [xbar_pkg::ids_bits-1:0]    def_id;
    logic [xbar_pkg::len_bits-1:0]    def_cnt;

    always_comb begin
        src_valid  = {def_busy, s1_r.valid, s0_r.valid};
        src_pld[0] = '{id: s0_r.id, data: s0_r.data, resp: s0_r.resp, last: s0_r.last};
        src_pld[1] = '{id: s1_r.id, data: s1_r.data, resp: s1_r.resp, last: s1_r.last};
        src_pld[2] = '{id: def_id, data: '0, resp: xbar_pkg::resp_decerr,
                       last: def_cnt == '0};
        for (int s = 0; s <= xbar_pkg::num_slaves; s++) begin
            src_dst[s] = src_pld[s].id[xbar_pkg::ids_bits-1];
        end
    end

    // --------------------
    // Beat arbitration per master
    always_comb begin
        int idx;
        for (int m = 0; m < xbar_pkg::num_masters; m++) begin
            sel[m]       = lst[m];
            mst_valid[m] = 1'b0;
            // Walk back toward the last winner so the nearest source wins
            for (int k = xbar_pkg::num_slaves + 1; k > 0; k--) begin
                idx = (lst[m] + k) % (xbar_pkg::num_slaves + 1);
                if (src_valid[idx] && src_dst[idx] == m) begin
                    sel[m]       = 2'(idx);
                    mst_valid[m] = 1'b1;
                end
            end
        end
        for (int s = 0; s <= xbar_pkg::num_slaves; s++) begin
            src_ready[s] = mst_ready[src_dst[s]] && (sel[src_dst[s]] == s);
        end
        for (int s = 0; s < xbar_pkg::num_slaves; s++) begin
            burst_done[s] = src_fire[s] && src_pld[s].last;
        end
    end

    assign src_fire  = src_valid & src_ready;
    assign mst_ready = {m1_r_ready, m0_r_ready};

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            for (int m = 0; m < xbar_pkg::num_masters; m++) begin
                lst[m] <= 2'(xbar_pkg::num_slaves);
            end
            def_busy <= 1'b0;
        end else begin
            for (int m = 0; m < xbar_pkg::num_masters; m++) begin
                if (mst_valid[m] && mst_ready[m]) begin
                    lst[m] <= sel[m];
                end
            end
            if (def_ar.valid && def_ar.ready) begin
                def_busy <= 1'b1;
            end else if (src_fire[2] && src_pld[2].last) begin
                def_busy <= 1'b0;
            end
        end
    end

    // DECERR beat counter, counts down to the last beat
    always_ff @(posedge ACLK) begin
        if (def_ar.valid && def_ar.ready) begin
            def_id  <= def_ar.id;
            def_cnt <= def_ar.len;
        end else if (src_fire[2]) begin
            def_cnt <= def_cnt - 1'b1;
        end
    end

    assign def_ar.ready = !def_busy;
    assign s0_r.ready   = src_ready[0];
    assign s1_r.ready   = src_ready[1];

    assign m0_r_valid   = mst_valid[0];
    assign m0_r_payload = src_pld[sel[0]];
    assign m1_r_valid   = mst_valid[1];
    assign m1_r_payload = src_pld[sel[1]];

endmodule

/* verilog/xbar_pkg.sv */
package xbar_pkg;

    // --------------------
    // Widths and counts
    localparam int addr_bits   = 32;
    localparam int data_bits   = 32;
    localparam int id_bits     = 4;
    localparam int num_masters = 2;
    localparam int num_slaves  = 2;
    // Master index sits above the master ID
    localparam int ids_bits    = id_bits + $clog2(num_masters);
    localparam int len_bits    = 4;
    localparam int size_bits   = 3;
    localparam int burst_bits  = 2;

    // --------------------
    // Address map
    localparam logic [addr_bits-1:0] s0_start = 32'h0000_0000;
    localparam logic [addr_bits-1:0] s0_end   = 32'h0000_FFFF;
    localparam logic [addr_bits-1:0] s1_start = 32'h0001_0000;
    localparam logic [addr_bits-1:0] s1_end   = 32'h0001_FFFF;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_decerr = 2'b11;

    typedef enum logic [1:0] {
        tgt_s0,
        tgt_s1,
        tgt_default
    } target_t;

    typedef struct packed {
        logic [ids_bits-1:0]   id;
        logic [addr_bits-1:0]  addr;
        logic [len_bits-1:0]   len;
        logic [size_bits-1:0]  size;
        logic [burst_bits-1:0] burst;
    } ar_payload_t;

    typedef struct packed {
        logic [ids_bits-1:0]  id;
        logic [data_bits-1:0] data;
        logic [1:0]           resp;
        logic                 last;
    } r_payload_t;

endpackage
